// File: rtl/ex_pkg.sv
`default_nettype none

package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  strb_t;

    typedef enum logic [4:0] {
        op_nop,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        op_jirl,
        op_div_w,
        op_mod_w,
        op_div_wu,
        op_mod_wu,
        op_ld_b,
        op_ld_h,
        op_ld_w,
        op_st_b,
        op_st_h,
        op_st_w
    } ex_op_t;

    typedef enum logic [1:0] {
        sel_alu,
        sel_branch,
        sel_div,
        sel_mem
    } unit_sel_t;

    typedef enum logic [1:0] {
        div_idle,
        div_busy,
        div_done
    } div_state_t;

    localparam int DIV_STEPS = 32;
    localparam int ADDR_LSB  = 2;

endpackage

`default_nettype wire

// File: rtl/ex_ifs.sv
`default_nettype none

// issue register to execute stage
interface issue_if;
    logic              valid;
    ex_pkg::word_t     pc;
    ex_pkg::ex_op_t    op;
    ex_pkg::word_t     src1;
    ex_pkg::word_t     src2;
    ex_pkg::word_t     imm;
    ex_pkg::reg_addr_t rd;

    modport source (output valid, pc, op, src1, src2, imm, rd);
    modport sink   (input  valid, pc, op, src1, src2, imm, rd);
endinterface

// execute stage to result register
interface exres_if;
    logic              valid;
    ex_pkg::reg_addr_t rd;
    logic              wb_en;
    ex_pkg::word_t     result;
    logic              is_mem;
    logic              mem_we;
    logic              ale;

    modport source (output valid, rd, wb_en, result, is_mem, mem_we, ale);
    modport sink   (input  valid, rd, wb_en, result, is_mem, mem_we, ale);
endinterface

`default_nettype wire

// File: rtl/ex_issue_reg.sv
`default_nettype none

module ex_issue_reg (
    input  wire logic              clk,
    input  wire logic              rst_i,
    input  wire logic              in_valid_i,
    input  wire ex_pkg::word_t     in_pc_i,
    input  wire ex_pkg::ex_op_t    in_op_i,
    input  wire ex_pkg::word_t     in_src1_i,
    input  wire ex_pkg::word_t     in_src2_i,
    input  wire ex_pkg::word_t     in_imm_i,
    input  wire ex_pkg::reg_addr_t in_rd_i,
    input  wire logic              stall_i,
    input  wire logic              flush_i,
    issue_if.source                iss
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            iss.valid <= 1'b0;
        end else if (!stall_i) begin
            // younger instruction behind a taken branch enters dead
            iss.valid <= in_valid_i && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            iss.pc   <= in_pc_i;
            iss.op   <= in_op_i;
            iss.src1 <= in_src1_i;
            iss.src2 <= in_src2_i;
            iss.imm  <= in_imm_i;
            iss.rd   <= in_rd_i;
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst_i)
        stall_i |=> $stable({iss.valid, iss.pc, iss.op, iss.src1, iss.src2, iss.imm, iss.rd}));

endmodule

`default_nettype wire

// File: rtl/ex_alu.sv
`default_nettype none

module ex_alu (
    input  wire ex_pkg::ex_op_t op_i,
    input  wire ex_pkg::word_t  pc_i,
    input  wire ex_pkg::word_t  src1_i,
    input  wire ex_pkg::word_t  src2_i,
    input  wire ex_pkg::word_t  imm_i,
    output ex_pkg::word_t       result_o,
    output logic                taken_o,
    output ex_pkg::word_t       target_o,
    output ex_pkg::word_t       link_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = src2_i[4:0];
    assign lt_s  = $signed(src1_i) < $signed(src2_i);
    assign lt_u  = src1_i < src2_i;

    always_comb begin
        case (op_i)
            ex_pkg::op_add:  result_o = src1_i + src2_i;
            ex_pkg::op_sub:  result_o = src1_i - src2_i;
            ex_pkg::op_and:  result_o = src1_i & src2_i;
            ex_pkg::op_or:   result_o = src1_i | src2_i;
            ex_pkg::op_xor:  result_o = src1_i ^ src2_i;
            ex_pkg::op_sll:  result_o = src1_i << shamt;
            ex_pkg::op_srl:  result_o = src1_i >> shamt;
            ex_pkg::op_sra:  result_o = ex_pkg::word_t'($signed(src1_i) >>> shamt);
            ex_pkg::op_slt:  result_o = {31'd0, lt_s};
            ex_pkg::op_sltu: result_o = {31'd0, lt_u};
            default:         result_o = '0;
        endcase
    end

    // branch condition
    always_comb begin
        case (op_i)
            ex_pkg::op_beq:  taken_o = src1_i == src2_i;
            ex_pkg::op_bne:  taken_o = src1_i != src2_i;
            ex_pkg::op_blt:  taken_o = lt_s;
            ex_pkg::op_bge:  taken_o = !lt_s;
            ex_pkg::op_bltu: taken_o = lt_u;
            ex_pkg::op_bgeu: taken_o = !lt_u;
            ex_pkg::op_jirl: taken_o = 1'b1;
            default:         taken_o = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target_o = (op_i == ex_pkg::op_jirl) ? src1_i + imm_i : pc_i + imm_i;
    assign link_o   = pc_i + 32'd4;

endmodule

`default_nettype wire

// File: rtl/ex_div.sv
`default_nettype none

module ex_div (
    input  wire logic          clk,
    input  wire logic          rst_i,
    input  wire logic          start_i,
    input  wire logic          signed_i,
    input  wire ex_pkg::word_t dividend_i,
    input  wire ex_pkg::word_t divisor_i,
    output logic               busy_o,
    output logic               done_o,
    output ex_pkg::word_t      quotient_o,
    output ex_pkg::word_t      remainder_o
);

    ex_pkg::div_state_t state;
    logic [5:0]         step_cnt;
    ex_pkg::word_t      quot;
    ex_pkg::word_t      rem;
    ex_pkg::word_t      dvs;
    logic               neg_q;
    logic               neg_r;
    logic               dividend_neg;
    logic               divisor_neg;
    logic [32:0]        rem_shift;
    logic [33:0]        diff;

    assign dividend_neg = signed_i && dividend_i[31];
    assign divisor_neg  = signed_i && divisor_i[31];

    // one restoring step per busy cycle
    assign rem_shift = {rem, quot[31]};
    assign diff      = {1'b0, rem_shift} - {2'b00, dvs};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state    <= ex_pkg::div_idle;
            step_cnt <= '0;
        end else begin
            case (state)
                ex_pkg::div_idle: begin
                    if (start_i) begin
                        state    <= ex_pkg::div_busy;
                        step_cnt <= '0;
                    end
                end
                ex_pkg::div_busy: begin
                    step_cnt <= step_cnt + 6'd1;
                    if (step_cnt == 6'(ex_pkg::DIV_STEPS - 1)) begin
                        state <= ex_pkg::div_done;
                    end
                end
                default: state <= ex_pkg::div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_i && state == ex_pkg::div_idle) begin
            quot  <= dividend_neg ? -dividend_i : dividend_i;
            dvs   <= divisor_neg ? -divisor_i : divisor_i;
            rem   <= '0;
            neg_q <= dividend_neg ^ divisor_neg;
            neg_r <= dividend_neg;
        end else if (state == ex_pkg::div_busy) begin
            if (!diff[33]) begin
                rem  <= diff[31:0];
                quot <= {quot[30:0], 1'b1};
            end else begin
                rem  <= rem_shift[31:0];
                quot <= {quot[30:0], 1'b0};
            end
        end
    end

    assign busy_o      = state == ex_pkg::div_busy;
    assign done_o      = state == ex_pkg::div_done;
    // remainder follows the dividend sign
    assign quotient_o  = neg_q ? -quot : quot;
    assign remainder_o = neg_r ? -rem : rem;

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst_i) start_i |-> !busy_o);

endmodule

`default_nettype wire

// File: rtl/ex_lsu_agen.sv
`default_nettype none

module ex_lsu_agen (
    input  wire ex_pkg::ex_op_t op_i,
    input  wire ex_pkg::word_t  base_i,
    input  wire ex_pkg::word_t  offset_i,
    input  wire ex_pkg::word_t  data_i,
    output ex_pkg::word_t       addr_o,
    output ex_pkg::word_t       wdata_o,
    output ex_pkg::strb_t       wstrb_o,
    output logic                we_o,
    output logic                ale_o
);

    logic [ex_pkg::ADDR_LSB-1:0] lane;
    logic [4:0]                  bit_sh;
    logic                        is_half;
    logic                        is_word;

    assign addr_o  = base_i + offset_i;
    assign lane    = addr_o[ex_pkg::ADDR_LSB-1:0];
    assign bit_sh  = {lane, 3'b000};
    assign is_half = (op_i == ex_pkg::op_ld_h) || (op_i == ex_pkg::op_st_h);
    assign is_word = (op_i == ex_pkg::op_ld_w) || (op_i == ex_pkg::op_st_w);

    assign ale_o = (is_half && lane[0]) || (is_word && (lane != '0));
    assign we_o  = (op_i == ex_pkg::op_st_b) || (op_i == ex_pkg::op_st_h) ||
                   (op_i == ex_pkg::op_st_w);

    always_comb begin
        wdata_o = '0;
        wstrb_o = 4'b1111;
        case (op_i)
            ex_pkg::op_st_b: begin
                wdata_o = ex_pkg::word_t'(data_i[7:0]) << bit_sh;
                wstrb_o = 4'b0001 << lane;
            end
            ex_pkg::op_st_h: begin
                wdata_o = ex_pkg::word_t'(data_i[15:0]) << bit_sh;
                wstrb_o = 4'b0011 << lane;
            end
            ex_pkg::op_st_w: begin
                wdata_o = data_i;
            end
            default: begin
                wdata_o = '0;
            end
        endcase
        // misaligned store writes nothing
        if (we_o && ale_o) begin
            wstrb_o = '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ex_stage.sv
`default_nettype none

module ex_stage (
    input  wire logic     clk,
    input  wire logic     rst_i,
    issue_if.sink         iss,
    exres_if.source       res,
    input  wire logic     mem_addr_ok_i,
    output logic          stall_o,
    output logic          flush_o,
    output ex_pkg::word_t flush_target_o,
    output logic          mem_req_o,
    output logic          mem_we_o,
    output ex_pkg::word_t mem_addr_o,
    output ex_pkg::word_t mem_wdata_o,
    output ex_pkg::strb_t mem_wstrb_o
);

    ex_pkg::unit_sel_t sel;
    ex_pkg::word_t     alu_result;
    ex_pkg::word_t     link;
    ex_pkg::word_t     quotient;
    ex_pkg::word_t     remainder;
    logic              taken;
    logic              ale;
    logic              div_start;
    logic              div_busy;
    logic              div_done;
    logic              div_started;
    logic              div_signed;
    logic              is_mod;

    always_comb begin
        case (iss.op)
            ex_pkg::op_beq, ex_pkg::op_bne, ex_pkg::op_blt, ex_pkg::op_bge,
            ex_pkg::op_bltu, ex_pkg::op_bgeu, ex_pkg::op_jirl: sel = ex_pkg::sel_branch;
            ex_pkg::op_div_w, ex_pkg::op_mod_w,
            ex_pkg::op_div_wu, ex_pkg::op_mod_wu:              sel = ex_pkg::sel_div;
            ex_pkg::op_ld_b, ex_pkg::op_ld_h, ex_pkg::op_ld_w,
            ex_pkg::op_st_b, ex_pkg::op_st_h, ex_pkg::op_st_w: sel = ex_pkg::sel_mem;
            default:                                           sel = ex_pkg::sel_alu;
        endcase
    end

    ex_alu i_alu (
        .op_i     (iss.op),
        .pc_i     (iss.pc),
        .src1_i   (iss.src1),
        .src2_i   (iss.src2),
        .imm_i    (iss.imm),
        .result_o (alu_result),
        .taken_o  (taken),
        .target_o (flush_target_o),
        .link_o   (link)
    );

    assign div_signed = (iss.op == ex_pkg::op_div_w) || (iss.op == ex_pkg::op_mod_w);
    assign is_mod     = (iss.op == ex_pkg::op_mod_w) || (iss.op == ex_pkg::op_mod_wu);
    // start once per divide, started stays set through the done cycle
    assign div_start  = iss.valid && (sel == ex_pkg::sel_div) && !div_started;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            div_started <= 1'b0;
        end else if (div_start) begin
            div_started <= 1'b1;
        end else if (div_done) begin
            div_started <= 1'b0;
        end
    end

    ex_div i_div (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (div_start),
        .signed_i    (div_signed),
        .dividend_i  (iss.src1),
        .divisor_i   (iss.src2),
        .busy_o      (div_busy),
        .done_o      (div_done),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    ex_lsu_agen i_agen (
        .op_i     (iss.op),
        .base_i   (iss.src1),
        .offset_i (iss.imm),
        .data_i   (iss.src2),
        .addr_o   (mem_addr_o),
        .wdata_o  (mem_wdata_o),
        .wstrb_o  (mem_wstrb_o),
        .we_o     (mem_we_o),
        .ale_o    (ale)
    );

    assign mem_req_o = iss.valid && (sel == ex_pkg::sel_mem) && !ale;
    assign flush_o   = iss.valid && (sel == ex_pkg::sel_branch) && taken;
    assign stall_o   = div_start || div_busy || (mem_req_o && !mem_addr_ok_i);

    always_comb begin
        case (sel)
            ex_pkg::sel_branch: begin
                res.result = link;
                res.wb_en  = iss.op == ex_pkg::op_jirl;
            end
            ex_pkg::sel_div: begin
                res.result = is_mod ? remainder : quotient;
                res.wb_en  = 1'b1;
            end
            ex_pkg::sel_mem: begin
                res.result = mem_addr_o;
                res.wb_en  = 1'b0;
            end
            default: begin
                res.result = alu_result;
                res.wb_en  = iss.op != ex_pkg::op_nop;
            end
        endcase
    end

    assign res.valid  = iss.valid;
    assign res.rd     = iss.rd;
    assign res.is_mem = sel == ex_pkg::sel_mem;
    assign res.mem_we = mem_we_o;
    assign res.ale    = res.is_mem && ale;

    // a request never carries a misaligned address
    a_no_req_on_ale: assert property (@(posedge clk) disable iff (rst_i)
        mem_req_o |-> !(mem_addr_o[0] && (iss.op inside {ex_pkg::op_ld_h, ex_pkg::op_st_h})) &&
            !((mem_addr_o[1:0] != 2'b00) && (iss.op inside {ex_pkg::op_ld_w, ex_pkg::op_st_w})));

endmodule

`default_nettype wire

// File: rtl/ex_result_reg.sv
`default_nettype none

module ex_result_reg (
    input  wire logic         clk,
    input  wire logic         rst_i,
    input  wire logic         stall_i,
    exres_if.sink             res,
    output logic              out_valid_o,
    output ex_pkg::reg_addr_t out_rd_o,
    output logic              out_wb_en_o,
    output ex_pkg::word_t     out_result_o,
    output logic              out_is_mem_o,
    output logic              out_ale_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
        end else begin
            // bubble until the stalled instruction completes
            out_valid_o <= res.valid && !stall_i;
        end
    end

    always_ff @(posedge clk) begin
        out_rd_o     <= res.rd;
        out_wb_en_o  <= res.wb_en;
        out_result_o <= res.result;
        out_is_mem_o <= res.is_mem;
        out_ale_o    <= res.ale;
    end

    a_store_no_wb: assert property (@(posedge clk) disable iff (rst_i)
        res.valid && res.mem_we && !stall_i |=> !out_wb_en_o);

endmodule

`default_nettype wire

// File: rtl/ex_top.sv
`default_nettype none

module ex_top (
    input  wire logic              clk,
    input  wire logic              rst_i,
    input  wire logic              in_valid_i,
    input  wire ex_pkg::word_t     in_pc_i,
    input  wire ex_pkg::ex_op_t    in_op_i,
    input  wire ex_pkg::word_t     in_src1_i,
    input  wire ex_pkg::word_t     in_src2_i,
    input  wire ex_pkg::word_t     in_imm_i,
    input  wire ex_pkg::reg_addr_t in_rd_i,
    input  wire logic              mem_addr_ok_i,
    output logic                   stall_o,
    output logic                   flush_o,
    output ex_pkg::word_t          flush_target_o,
    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output ex_pkg::word_t          mem_addr_o,
    output ex_pkg::word_t          mem_wdata_o,
    output ex_pkg::strb_t          mem_wstrb_o,
    output logic                   out_valid_o,
    output ex_pkg::reg_addr_t      out_rd_o,
    output logic                   out_wb_en_o,
    output ex_pkg::word_t          out_result_o,
    output logic                   out_is_mem_o,
    output logic                   out_ale_o
);

    issue_if iss_bus ();
    exres_if res_bus ();

    ex_issue_reg i_issue_reg (
        .clk(clk), .rst_i(rst_i),
        .in_valid_i(in_valid_i), .in_pc_i(in_pc_i), .in_op_i(in_op_i),
        .in_src1_i(in_src1_i), .in_src2_i(in_src2_i), .in_imm_i(in_imm_i),
        .in_rd_i(in_rd_i), .stall_i(stall_o), .flush_i(flush_o), .iss(iss_bus)
    );

    ex_stage i_stage (
        .clk(clk), .rst_i(rst_i), .iss(iss_bus), .res(res_bus),
        .mem_addr_ok_i(mem_addr_ok_i), .stall_o(stall_o), .flush_o(flush_o),
        .flush_target_o(flush_target_o), .mem_req_o(mem_req_o), .mem_we_o(mem_we_o),
        .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o), .mem_wstrb_o(mem_wstrb_o)
    );

    ex_result_reg i_result_reg (
        .clk(clk), .rst_i(rst_i), .stall_i(stall_o), .res(res_bus),
        .out_valid_o(out_valid_o), .out_rd_o(out_rd_o), .out_wb_en_o(out_wb_en_o),
        .out_result_o(out_result_o), .out_is_mem_o(out_is_mem_o), .out_ale_o(out_ale_o)
    );

endmodule

`default_nettype wire

// File: test/tb_ex_top.sv
`default_nettype none

module tb_ex_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CYCLES  = 4000;
    localparam int DRAIN_LIMIT = 200;
    localparam int OCC_LIMIT   = 100;

    typedef struct packed {
        ex_pkg::ex_op_t    op;
        ex_pkg::word_t     pc;
        ex_pkg::word_t     src1;
        ex_pkg::word_t     src2;
        ex_pkg::word_t     imm;
        ex_pkg::reg_addr_t rd;
    } instr_t;

    typedef struct packed {
        ex_pkg::reg_addr_t rd;
        logic              wb_en;
        ex_pkg::word_t     result;
        logic              chk_result;
        logic              is_mem;
        logic              ale;
        logic [31:0]       latency;
        logic [31:0]       acc_cyc;
    } rec_t;

    logic              clk;
    logic              rst_i;
    logic              in_valid_i;
    ex_pkg::word_t     in_pc_i;
    ex_pkg::ex_op_t    in_op_i;
    ex_pkg::word_t     in_src1_i;
    ex_pkg::word_t     in_src2_i;
    ex_pkg::word_t     in_imm_i;
    ex_pkg::reg_addr_t in_rd_i;
    logic              mem_addr_ok_i;
    logic              stall_o;
    logic              flush_o;
    ex_pkg::word_t     flush_target_o;
    logic              mem_req_o;
    logic              mem_we_o;
    ex_pkg::word_t     mem_addr_o;
    ex_pkg::word_t     mem_wdata_o;
    ex_pkg::strb_t     mem_wstrb_o;
    logic              out_valid_o;
    ex_pkg::reg_addr_t out_rd_o;
    logic              out_wb_en_o;
    ex_pkg::word_t     out_result_o;
    logic              out_is_mem_o;
    logic              out_ale_o;

    instr_t      pending;
    instr_t      cur;
    logic        cur_valid;
    int          cur_occ;
    logic        holding;
    logic        aborted;
    int          cyc;
    int          errors;
    int          checks;
    int          retired;
    int          squashed;
    rec_t        exp_q[$];

    ex_pkg::ex_op_t alu_ops [10] = '{ex_pkg::op_add, ex_pkg::op_sub, ex_pkg::op_and,
        ex_pkg::op_or, ex_pkg::op_xor, ex_pkg::op_sll, ex_pkg::op_srl, ex_pkg::op_sra,
        ex_pkg::op_slt, ex_pkg::op_sltu};
    ex_pkg::ex_op_t br_ops [7] = '{ex_pkg::op_beq, ex_pkg::op_bne, ex_pkg::op_blt,
        ex_pkg::op_bge, ex_pkg::op_bltu, ex_pkg::op_bgeu, ex_pkg::op_jirl};
    ex_pkg::ex_op_t div_ops [4] = '{ex_pkg::op_div_w, ex_pkg::op_mod_w, ex_pkg::op_div_wu,
        ex_pkg::op_mod_wu};
    ex_pkg::ex_op_t mem_ops [6] = '{ex_pkg::op_ld_b, ex_pkg::op_ld_h, ex_pkg::op_ld_w,
        ex_pkg::op_st_b, ex_pkg::op_st_h, ex_pkg::op_st_w};

    ex_top i_dut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic is_branch(ex_pkg::ex_op_t op);
        return op inside {ex_pkg::op_beq, ex_pkg::op_bne, ex_pkg::op_blt, ex_pkg::op_bge,
                          ex_pkg::op_bltu, ex_pkg::op_bgeu, ex_pkg::op_jirl};
    endfunction

    function automatic logic is_div(ex_pkg::ex_op_t op);
        return op inside {ex_pkg::op_div_w, ex_pkg::op_mod_w, ex_pkg::op_div_wu,
                          ex_pkg::op_mod_wu};
    endfunction

    function automatic logic is_store(ex_pkg::ex_op_t op);
        return op inside {ex_pkg::op_st_b, ex_pkg::op_st_h, ex_pkg::op_st_w};
    endfunction

    function automatic logic is_mem(ex_pkg::ex_op_t op);
        return is_store(op) || (op inside {ex_pkg::op_ld_b, ex_pkg::op_ld_h, ex_pkg::op_ld_w});
    endfunction

    function automatic logic lt_signed(ex_pkg::word_t a, ex_pkg::word_t b);
        // differing signs decide on their own
        if (a[31] != b[31]) begin
            return a[31];
        end
        return a < b;
    endfunction

    function automatic ex_pkg::word_t alu_model(instr_t i);
        ex_pkg::word_t a;
        ex_pkg::word_t b;
        ex_pkg::word_t fill;
        a = i.src1;
        b = i.src2;
        fill = a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0;
        case (i.op)
            ex_pkg::op_add:  return a + b;
            ex_pkg::op_sub:  return a - b;
            ex_pkg::op_and:  return a & b;
            ex_pkg::op_or:   return a | b;
            ex_pkg::op_xor:  return a ^ b;
            ex_pkg::op_sll:  return a << b[4:0];
            ex_pkg::op_srl:  return a >> b[4:0];
            ex_pkg::op_sra:  return (a >> b[4:0]) | fill;
            ex_pkg::op_slt:  return {31'd0, lt_signed(a, b)};
            ex_pkg::op_sltu: return {31'd0, a < b};
            default:         return 32'h0;
        endcase
    endfunction

    function automatic logic branch_taken(instr_t i);
        case (i.op)
            ex_pkg::op_beq:  return i.src1 == i.src2;
            ex_pkg::op_bne:  return i.src1 != i.src2;
            ex_pkg::op_blt:  return lt_signed(i.src1, i.src2);
            ex_pkg::op_bge:  return !lt_signed(i.src1, i.src2);
            ex_pkg::op_bltu: return i.src1 < i.src2;
            ex_pkg::op_bgeu: return i.src1 >= i.src2;
            ex_pkg::op_jirl: return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

    function automatic ex_pkg::word_t branch_target(instr_t i);
        return (i.op == ex_pkg::op_jirl) ? i.src1 + i.imm : i.pc + i.imm;
    endfunction

    function automatic ex_pkg::word_t div_model(instr_t i);
        logic          sgn;
        logic          na;
        logic          nb;
        ex_pkg::word_t ma;
        ex_pkg::word_t mb;
        ex_pkg::word_t q;
        ex_pkg::word_t r;
        sgn = (i.op == ex_pkg::op_div_w) || (i.op == ex_pkg::op_mod_w);
        na = sgn && i.src1[31];
        nb = sgn && i.src2[31];
        ma = na ? -i.src1 : i.src1;
        mb = nb ? -i.src2 : i.src2;
        if (mb == 32'h0) begin
            q = '1;
            r = ma;
        end else begin
            q = ma / mb;
            r = ma % mb;
        end
        if (na ^ nb) begin
            q = -q;
        end
        if (na) begin
            r = -r;
        end
        return (i.op == ex_pkg::op_mod_w || i.op == ex_pkg::op_mod_wu) ? r : q;
    endfunction

    function automatic void agen_model(input instr_t i, output ex_pkg::word_t addr,
                                       output logic ale, output ex_pkg::word_t wdata,
                                       output ex_pkg::strb_t wstrb);
        logic [1:0] lane;
        logic [4:0] sh;
        addr = i.src1 + i.imm;
        lane = addr[1:0];
        sh = {lane, 3'b000};
        ale = ((i.op == ex_pkg::op_ld_h || i.op == ex_pkg::op_st_h) && lane[0]) ||
              ((i.op == ex_pkg::op_ld_w || i.op == ex_pkg::op_st_w) && lane != 2'b00);
        wdata = 32'h0;
        wstrb = 4'hf;
        case (i.op)
            ex_pkg::op_st_b: begin
                wdata = {24'd0, i.src2[7:0]} << sh;
                wstrb = 4'b0001 << lane;
            end
            ex_pkg::op_st_h: begin
                wdata = {16'd0, i.src2[15:0]} << sh;
                wstrb = 4'b0011 << lane;
            end
            ex_pkg::op_st_w: wdata = i.src2;
            default:         wdata = 32'h0;
        endcase
    endfunction

    function automatic rec_t expect_record(instr_t i, int acc);
        rec_t          e;
        ex_pkg::word_t addr;
        ex_pkg::word_t wdata;
        ex_pkg::strb_t wstrb;
        logic          ale;
        e = '0;
        e.rd = i.rd;
        e.acc_cyc = 32'(acc);
        e.latency = 32'd2;
        e.chk_result = 1'b1;
        if (is_branch(i.op)) begin
            e.result = i.pc + 32'd4;
            e.wb_en = i.op == ex_pkg::op_jirl;
            e.chk_result = e.wb_en;
        end else if (is_div(i.op)) begin
            e.result = div_model(i);
            e.wb_en = 1'b1;
            // start cycle, busy steps, done cycle, then out
            e.latency = 32'(ex_pkg::DIV_STEPS + 3);
        end else if (is_mem(i.op)) begin
            agen_model(i, addr, ale, wdata, wstrb);
            e.result = addr;
            e.is_mem = 1'b1;
            e.ale = ale;
            e.latency = ale ? 32'd2 : 32'd0;
        end else begin
            e.result = alu_model(i);
            e.wb_en = 1'b1;
        end
        return e;
    endfunction

    function automatic ex_pkg::word_t pick_operand();
        case ($urandom % 8)
            0:       return 32'h0;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'($urandom % 16);
            default: return $urandom;
        endcase
    endfunction

    task automatic gen_instr(output instr_t i);
        int cls;
        cls = $urandom % 100;
        i.pc = $urandom & 32'hffff_fffc;
        i.rd = 5'($urandom);
        i.src1 = pick_operand();
        i.src2 = pick_operand();
        i.imm = $urandom & 32'h0000_0ffc;
        if (cls < 40) begin
            i.op = alu_ops[$urandom % 10];
        end else if (cls < 60) begin
            i.op = br_ops[$urandom % 7];
            if ($urandom % 3 == 0) begin
                i.src2 = i.src1;
            end
        end else if (cls < 70) begin
            i.op = div_ops[$urandom % 4];
        end else begin
            // low offset bits give plenty of misaligned accesses
            i.op = mem_ops[$urandom % 6];
            i.src1 = $urandom;
            i.imm = $urandom % 64;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%0t %s", $time, what);
            errors++;
        end
    endtask

    task automatic check_quiet();
        check_value("out_valid_o", 32'(out_valid_o), 32'd0);
        check_value("mem_req_o", 32'(mem_req_o), 32'd0);
        check_value("flush_o", 32'(flush_o), 32'd0);
        check_value("stall_o", 32'(stall_o), 32'd0);
    endtask

    task automatic check_record(input rec_t e);
        int lat;
        lat = cyc - int'(e.acc_cyc);
        retired++;
        check_value("out_rd_o", 32'(out_rd_o), 32'(e.rd));
        check_value("out_wb_en_o", 32'(out_wb_en_o), 32'(e.wb_en));
        check_value("out_is_mem_o", 32'(out_is_mem_o), 32'(e.is_mem));
        check_value("out_ale_o", 32'(out_ale_o), 32'(e.ale));
        if (e.chk_result) begin
            check_value("out_result_o", out_result_o, e.result);
        end
        if (e.latency != 32'd0) begin
            check_true(lat == int'(e.latency), $sformatf(
                "record for rd %0d left %0d cycles after acceptance instead of %0d",
                e.rd, lat, e.latency));
        end else begin
            check_true(lat >= 2, $sformatf("memory record for rd %0d left too early", e.rd));
        end
    endtask

    // one clock cycle, entered and left 1 ns after the rising edge
    task automatic run_cycle(input logic allow_new);
        rec_t          e;
        logic          accepted;
        logic          exp_flush;
        logic          exp_req;
        logic          exp_stall;
        logic          ale;
        ex_pkg::word_t addr;
        ex_pkg::word_t wdata;
        ex_pkg::word_t mask;
        ex_pkg::strb_t wstrb;
        if (!holding) begin
            if (allow_new && ($urandom % 100) < 80) begin
                gen_instr(pending);
                in_valid_i = 1'b1;
                in_pc_i = pending.pc;
                in_op_i = pending.op;
                in_src1_i = pending.src1;
                in_src2_i = pending.src2;
                in_imm_i = pending.imm;
                in_rd_i = pending.rd;
            end else begin
                in_valid_i = 1'b0;
            end
        end
        mem_addr_ok_i = ($urandom % 100) < 45;
        #6;
        agen_model(cur, addr, ale, wdata, wstrb);
        exp_flush = cur_valid && is_branch(cur.op) && branch_taken(cur);
        exp_req = cur_valid && is_mem(cur.op) && !ale;
        if (cur_valid && is_div(cur.op)) begin
            exp_stall = cur_occ <= ex_pkg::DIV_STEPS + 1;
        end else begin
            exp_stall = exp_req && !mem_addr_ok_i;
        end
        check_value("flush_o", 32'(flush_o), 32'(exp_flush));
        if (exp_flush) begin
            check_value("flush_target_o", flush_target_o, branch_target(cur));
        end
        check_value("mem_req_o", 32'(mem_req_o), 32'(exp_req));
        if (exp_req) begin
            check_value("mem_we_o", 32'(mem_we_o), 32'(is_store(cur.op)));
            check_value("mem_addr_o", mem_addr_o, addr);
            check_value("mem_wstrb_o", 32'(mem_wstrb_o), 32'(wstrb));
            if (is_store(cur.op)) begin
                mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
                check_value("mem_wdata_o", mem_wdata_o & mask, wdata & mask);
            end
        end
        check_value("stall_o", 32'(stall_o), 32'(exp_stall));
        if (out_valid_o) begin
            check_true(exp_q.size() != 0, "out_valid_o high with no instruction outstanding");
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_record(e);
            end
        end
        accepted = in_valid_i && !stall_o;
        holding = in_valid_i && stall_o;
        if (accepted && flush_o) begin
            squashed++;
        end else if (accepted) begin
            exp_q.push_back(expect_record(pending, cyc));
        end
        if (!stall_o) begin
            cur_valid = accepted && !flush_o;
            cur = pending;
            cur_occ = 1;
        end else begin
            cur_occ++;
        end
        check_true(cur_occ <= OCC_LIMIT, "timeout, instruction stuck in the issue register");
        if (cur_occ > OCC_LIMIT) begin
            aborted = 1'b1;
        end
        cyc++;
        @(posedge clk);
        #1;
    endtask

    initial begin
        void'($urandom(32'he822));
        rst_i = 1'b1;
        in_valid_i = 1'b0;
        in_pc_i = 32'h0;
        in_op_i = ex_pkg::op_nop;
        in_src1_i = 32'h0;
        in_src2_i = 32'h0;
        in_imm_i = 32'h0;
        in_rd_i = 5'd0;
        mem_addr_ok_i = 1'b0;
        pending = '0;
        cur = '0;
        cur_valid = 1'b0;
        cur_occ = 0;
        holding = 1'b0;
        aborted = 1'b0;
        cyc = 0;
        errors = 0;
        checks = 0;
        retired = 0;
        squashed = 0;

        @(posedge clk);
        #7;
        check_quiet();
        @(posedge clk);
        #1;
        rst_i = 1'b0;
        #6;
        check_quiet();
        @(posedge clk);
        #1;

        for (int n = 0; n < NUM_CYCLES && !aborted; n++) begin
            run_cycle(1'b1);
        end
        // drain what is still in flight
        for (int t = 0; t < DRAIN_LIMIT && !aborted &&
             (exp_q.size() != 0 || holding || cur_valid); t++) begin
            run_cycle(1'b0);
        end
        check_true(exp_q.size() == 0, "timeout waiting for outstanding records to leave");

        $display("retired %0d, squashed %0d, checks %0d, errors %0d",
                 retired, squashed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
rtl/ex_pkg.sv
rtl/ex_ifs.sv
rtl/ex_issue_reg.sv
rtl/ex_alu.sv
rtl/ex_div.sv
rtl/ex_lsu_agen.sv
rtl/ex_stage.sv
rtl/ex_result_reg.sv
rtl/ex_top.sv
test/tb_ex_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the execute stage testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_ex_top --Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_ex_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
